//--- Bender.yml
package:
  name: mem_stage

sources:
  - verilog/mem_stage_pkg.sv
  - verilog/trap_csr.sv
  - verilog/ls_request.sv
  - verilog/retire_check.sv
  - verilog/wb_pipe.sv
  - verilog/mem_stage.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_clk_gen.sv
      - verif/mem_stage_tb.sv

//--- verif/mem_stage_vectors.svh
// memory stage stimulus table
// one row per instruction with its expected writeback, cause and retire class
`ifndef MEM_STAGE_VECTORS_SVH
`define MEM_STAGE_VECTORS_SVH

// columns of add_row: instr, max ack delay, fault, load data, mode, trap vector,
// writes back, expected cause, expected tval, retire class, mispredict
function automatic e2m_t ins(i_type_e t, logic [3:0] op, logic [XLEN-1:0] pc,
                             logic [XLEN-1:0] rd_data);
   e2m_t e;
   e                = '0;
   e.i_type         = t;
   e.op.br          = br_op_e'(op);                      // raw op word
   e.pc             = pc;
   e.instr          = 32'h0000_0013 | (pc << 12);        // tagged by pc
   e.rd_wr          = 1'b1;
   e.rd_addr        = pc[6:2];
   e.rd_data        = rd_data;
   e.size           = 3'd2;
   e.br_pc          = pc + 32'h40;
   e.predicted_addr = e.br_pc;                           // predicted right by default
   return e;
endfunction

task automatic add_row(e2m_t e, int dly, logic flt, logic [XLEN-1:0] ld, logic [1:0] md,
                       logic [XLEN-1:0] vec, logic wr, logic [3:0] cause,
                       logic [XLEN-1:0] tval, ret_class_e cls, logic misp);
   vectors.push_back('{e, dly, flt, ld, md, vec, wr, cause, tval, cls, misp});
endtask

task automatic load_vectors();
   e2m_t e;
   e = ins(ALU, 0, 'h100, 'h11);
   add_row(e, 0, 0, 0, M_MODE, 'h800, 1, NO_EXC, 0, RET_ALU, 0);
   e = ins(IM, 0, 'h104, 'h22);
   add_row(e, 0, 0, 0, M_MODE, 'h800, 1, NO_EXC, 0, RET_IM, 0);
   e = ins(IDR, 0, 'h108, 'h33);
   add_row(e, 0, 0, 0, M_MODE, 'h800, 1, NO_EXC, 0, RET_IDR, 0);
   e = ins(BR, JAL, 'h10c, 'h110);
   add_row(e, 0, 0, 0, M_MODE, 'h800, 1, NO_EXC, 0, RET_JAL, 0);
   e = ins(BR, JALR, 'h110, 'h114);
   add_row(e, 0, 0, 0, M_MODE, 'h800, 1, NO_EXC, 0, RET_JALR, 0);
   e = ins(BR, BXX, 'h114, 0);
   add_row(e, 0, 0, 0, M_MODE, 'h800, 0, NO_EXC, 0, RET_BXX, 0);
   e = ins(BR, BXX, 'h118, 0);
   e.predicted_addr = 'h11c;
   add_row(e, 0, 0, 0, M_MODE, 'h800, 0, NO_EXC, 0, RET_BXX, 1);
   e = ins(BR, JAL, 'h11c, 'h120);
   e.predicted_addr = 0;
   add_row(e, 0, 0, 0, M_MODE, 'h800, 0, NO_EXC, 0, RET_JAL, 1);
   e = ins(BR, JAL, 'h120, 'h124);
   e.mis = 1;
   add_row(e, 0, 0, 0, M_MODE, 'h800, 0, 4'd0, e.br_pc, RET_JAL, 0);
   e = ins(ILL, 0, 'h124, 0);
   add_row(e, 0, 0, 0, M_MODE, 'h900, 0, 4'd2, e.instr, RET_UNK, 0);
   e = ins(SYS, EBREAK, 'h128, 0);
   add_row(e, 0, 0, 0, M_MODE, 'h900, 0, 4'd3, e.instr, RET_SYS, 0);
   e = ins(SYS, ECALL, 'h12c, 0);
   add_row(e, 0, 0, 0, M_MODE, 'ha00, 0, 4'd11, e.instr, RET_SYS, 0);
   e = ins(SYS, ECALL, 'h130, 0);
   add_row(e, 0, 0, 0, U_MODE, 'ha00, 0, 4'd8, e.instr, RET_SYS, 0);
   e = ins(BR, MRET, 'h134, 0);
   add_row(e, 0, 0, 0, U_MODE, 'hb00, 0, 4'd2, e.instr, RET_BXX, 0);
   e = ins(BR, MRET, 'h138, 0);
   add_row(e, 0, 0, 0, M_MODE, 'hb00, 0, NO_EXC, 0, RET_BXX, 0);
   e = ins(CSR, 0, 'h13c, 'h44);
   add_row(e, 0, 0, 0, M_MODE, 'hb00, 1, NO_EXC, 0, RET_CSR, 0);
   e = ins(CSR, 0, 'h140, 'h345);
   e.mis = 1;
   add_row(e, 0, 0, 0, M_MODE, 'hb00, 0, 4'd1, 'h345, RET_CSR, 0);
   e = ins(LD, 0, 'h144, 0);
   e.ls_addr = 'h1000;
   add_row(e, 4, 0, 'hcafe_f00d, M_MODE, 'hb00, 1, NO_EXC, 0, RET_LD, 0);
   e = ins(LD, 0, 'h148, 0);
   e.ls_addr = 'h1004;
   e.size = 3'd1;
   e.zero_ext = 1;
   add_row(e, 0, 0, 'h0000_beef, M_MODE, 'hb00, 1, NO_EXC, 0, RET_LD, 0);
   e = ins(LD, 0, 'h14c, 0);
   e.ls_addr = 'h1001;
   e.mis = 1;
   add_row(e, 2, 0, 0, M_MODE, 'hc00, 0, 4'd4, 'h1001, RET_LD, 0);
   e = ins(LD, 0, 'h150, 0);
   e.ls_addr = 'h2000;
   add_row(e, 3, 1, 0, M_MODE, 'hc00, 0, 4'd5, 'h2000, RET_LD, 0);
   e = ins(ST, 0, 'h154, 0);
   e.ls_addr = 'h1008;
   e.st_data = 'h5555_aaaa;
   add_row(e, 5, 0, 0, M_MODE, 'hc00, 0, NO_EXC, 0, RET_ST, 0);
   e = ins(ST, 0, 'h158, 0);
   e.ls_addr = 'h100a;
   e.mis = 1;
   add_row(e, 1, 0, 0, M_MODE, 'hc00, 0, 4'd6, 'h100a, RET_ST, 0);
   e = ins(ST, 0, 'h15c, 0);
   e.ls_addr = 'h3000;
   add_row(e, 2, 1, 0, M_MODE, 'hc00, 0, 4'd7, 'h3000, RET_ST, 0);
   e = ins(ST, 0, 'h160, 0);
   e.inv_flag = 1;
   add_row(e, 3, 0, 0, M_MODE, 'hc00, 0, NO_EXC, 0, RET_ST, 0);
   e = ins(ST, 0, 'h164, 0);
   e.inv_flag = 1;
   e.ci = 1;
   add_row(e, 1, 0, 0, M_MODE, 'hc00, 0, NO_EXC, 0, RET_ST, 0);
   e = ins(ALU, 0, 'h168, 'h66);
   add_row(e, 0, 0, 0, M_MODE, 'hc00, 1, NO_EXC, 0, RET_ALU, 0);
   e = ins(IM, 0, 'h16c, 'h77);
   add_row(e, 0, 0, 0, M_MODE, 'hc00, 1, NO_EXC, 0, RET_IM, 0);
endtask

`endif

//--- verif/mem_stage_tb.sv
// memory stage testbench
// table driven instruction stream, memory model and writeback scoreboard
`timescale 1ns/100ps

module mem_stage_tb
   import mem_stage_pkg::*;
();

   localparam int         TIMEOUT   = 100;               // cycles per wait
   localparam logic [3:0] NO_EXC    = 4'hf;              // row raises no exception
   localparam int         FLUSH_ROW = 3;                 // flushed out of the pipe

   typedef struct {
      e2m_t            e;
      int              max_dly;
      logic            fault;
      logic [XLEN-1:0] ld_data;
      logic [1:0]      md;
      logic [XLEN-1:0] vec;
      logic            exp_wr;
      logic [3:0]      cause;
      logic [XLEN-1:0] tval;
      ret_class_e      cls;
      logic            misp;
   } row_t;

   logic clk_in, rst_n, pipe_flush, e2m_valid, e2m_ready, mio_req_valid, m2w_valid, m2w_ready;
   e2m_t      e2m;
   mio_req_t  mio_req;
   mio_rsp_t  mio_rsp;
   wb_t       m2w;
   fwd_t      fwd;
   events_t   events;
   reload_t   reload;
   cfg_wr_t   cfg_wr;
   trap_rec_t trap_rec;

   row_t   vectors[$];
   wb_t    wb_q[$];                                      // results expected on m2w
   integer seed = 40;
   int     ready_sel;                                    // 0 random, 1 high, 2 low

   `include "mem_stage_vectors.svh"

   tb_clk_gen tb_clk_gen_inst (.clk_in(clk_in), .rst_n(rst_n));

   mem_stage mem_stage_inst (.*);

   // ------------------------------------------------------------------------
   // error exit and compare tasks
   // ------------------------------------------------------------------------
   task automatic abort_run(string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_wb(string name, wb_t got, wb_t want);
      if (got !== want)
         abort_run($sformatf("FAIL %s got %h expected %h", name, got, want));
   endtask

   task automatic check_rec(string name, trap_rec_t got, trap_rec_t want);
      if (got !== want)
         abort_run($sformatf("FAIL %s got %h expected %h", name, got, want));
   endtask

   task automatic check_reload(string name, reload_t got, reload_t want);
      if (got !== want)
         abort_run($sformatf("FAIL %s got %h expected %h", name, got, want));
   endtask

   task automatic check_events(string name, events_t got, events_t want);
      if (got !== want)
         abort_run($sformatf("FAIL %s got %h expected %h", name, got, want));
   endtask

   task automatic check_req(string name, mio_req_t got, mio_req_t want);
      if (got !== want)
         abort_run($sformatf("FAIL %s got %h expected %h", name, got, want));
   endtask

   // ------------------------------------------------------------------------
   // cycle helpers
   // ------------------------------------------------------------------------
   task automatic drive_edge();
      @(posedge clk_in);
      #1;                                                // inputs change off the edge
      if (ready_sel == 1)
         m2w_ready = 1'b1;
      else if (ready_sel == 2)
         m2w_ready = 1'b0;
      else if ($unsigned($random(seed)) % 4 == 0)
         m2w_ready = !m2w_ready;                         // random stretches
   endtask

   task automatic sample_pop();
      wb_t want;
      @(negedge clk_in);
      if (m2w_valid && m2w_ready)
      begin
         if (wb_q.size() == 0)
            abort_run("writeback produced a result that was not expected");
         want = wb_q.pop_front();                        // table order
         check_wb("m2w", m2w, want);
      end
   endtask

   task automatic idle_cycle();
      drive_edge();
      sample_pop();
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial
   begin
      row_t     r;
      int       waited, dly, t;
      logic     is_ls, exc_exp, accepted;
      wb_t      exp_wb;
      reload_t  exp_rl;
      events_t  exp_ev;
      mio_req_t exp_req;

      pipe_flush = 1'b0;
      e2m_valid  = 1'b0;
      e2m        = '0;
      mio_rsp    = '0;
      m2w_ready  = 1'b0;
      cfg_wr     = '0;
      ready_sel  = 0;
      load_vectors();

      t = 0;
      while (rst_n !== 1'b1)
      begin
         @(posedge clk_in);
         t++;
         if (t > TIMEOUT)
            abort_run("reset was never released");
      end

      foreach (vectors[i])
      begin
         r       = vectors[i];
         is_ls   = (r.e.i_type == LD) || (r.e.i_type == ST);
         exc_exp = (r.cause != NO_EXC);
         if (i == FLUSH_ROW)
         begin
            ready_sel = 1;                               // drain, then hold the pipe
            idle_cycle();
            idle_cycle();
            ready_sel = 2;
            if (wb_q.size() != 0)
               abort_run("pipe did not drain before the flush");
         end
         drive_edge();
         cfg_wr = '{1'b1, CFG_VEC, r.vec};
         sample_pop();
         drive_edge();
         cfg_wr = '{1'b1, CFG_MODE, XLEN'(r.md)};
         sample_pop();

         dly      = is_ls ? $unsigned($random(seed)) % (r.max_dly + 1) : 0;
         exp_req  = '{r.e.i_type == LD, r.e.i_type == ST, r.e.ls_addr, r.e.st_data,
                      r.e.size, r.e.zero_ext};
         waited   = 0;
         t        = 0;
         accepted = 1'b0;
         while (!accepted)
         begin
            drive_edge();
            cfg_wr.valid  = 1'b0;
            e2m_valid     = 1'b1;
            e2m           = r.e;
            mio_rsp.ack   = is_ls && (waited >= dly);    // memory model answer
            mio_rsp.fault = r.fault;
            mio_rsp.data  = r.ld_data;
            sample_pop();
            if (m2w_valid && !m2w_ready && (e2m_ready || mio_req_valid))
               abort_run("stage did not stall while the writeback pipe was full");
            if (mio_req_valid)
            begin
               if (!is_ls)
                  abort_run("memory request raised for an instruction without memory access");
               check_req("mio_req", mio_req, exp_req);
               waited++;
            end
            if (e2m_ready)
            begin
               accepted = 1'b1;
               if (is_ls && !(mio_req_valid && mio_rsp.ack))
                  abort_run("load or store was accepted without a request and its ack");
               exp_wb = r.exp_wr ? wb_t'{1'b1, r.e.rd_addr,
                                         (r.e.i_type == LD) ? r.ld_data : r.e.rd_data} : '0;
               check_wb("fwd.wb", fwd.wb, exp_wb);
               if (!fwd.valid)
                  abort_run("forwarding was not valid in the accept cycle");
               if (exc_exp)
                  exp_rl = '{1'b1, 1'b0, r.vec};        // trap to the vector
               else if (r.e.i_type == ST && r.e.inv_flag)
                  exp_rl = '{1'b1, 1'b1, r.e.pc + (r.e.ci ? 32'd2 : 32'd4)};
               else
                  exp_rl = '0;
               check_reload("reload", reload, exp_rl);
               exp_ev            = '0;
               exp_ev.ret[r.cls] = 1'b1;
               exp_ev.e_flag     = exc_exp;
               exp_ev.e_cause    = exc_exp ? r.cause : '0;
               exp_ev.mispredict = r.misp;
               check_events("events", events, exp_ev);
               if (r.exp_wr)
                  wb_q.push_back(exp_wb);
            end
            else if (fwd.valid || events != '0 || reload != '0)
               abort_run("retire outputs were active in a cycle without an accept");
            t++;
            if (t > TIMEOUT)
               abort_run($sformatf("instruction at row %0d was never accepted", i));
         end
         drive_edge();
         e2m_valid = 1'b0;
         mio_rsp   = '0;
         sample_pop();
         if (exc_exp)
            check_rec("trap_rec", trap_rec, trap_rec_t'{r.e.pc, r.tval, r.cause});

         if (i == FLUSH_ROW)
         begin
            if (!m2w_valid || wb_q.size() != 1)
               abort_run("pipe was not holding one result before the flush");
            drive_edge();
            pipe_flush = 1'b1;
            sample_pop();
            drive_edge();
            pipe_flush = 1'b0;
            sample_pop();
            if (m2w_valid)
               abort_run("pipe still held a result after the flush");
            wb_q.delete();                               // dropped entry
            ready_sel = 0;
         end
      end

      ready_sel = 1;
      t = 0;
      while (wb_q.size() != 0)
      begin
         idle_cycle();
         t++;
         if (t > TIMEOUT)
            abort_run("writeback results were missing at the end of the run");
      end
      idle_cycle();
      if (m2w_valid)
         abort_run("pipe held an extra result at the end of the run");
      $display("Simulation passed");
      $finish;
   end

endmodule

//--- verif/tb_clk_gen.sv
// testbench clock and reset
// 100 ns clock, reset held low for the first 10 cycles
`timescale 1ns/100ps

module tb_clk_gen
(
   output logic clk_in,
   output logic rst_n
);

   initial
   begin
      clk_in = 1'b0;
      forever
         #50 clk_in = !clk_in;                           // half period
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (10) @(posedge clk_in);
      #1 rst_n = 1'b1;                                   // released off the edge
   end

endmodule

//--- verilog.f
+incdir+verif
verilog/mem_stage_pkg.sv
verilog/trap_csr.sv
verilog/ls_request.sv
verilog/retire_check.sv
verilog/wb_pipe.sv
verilog/mem_stage.sv
verif/tb_clk_gen.sv
verif/mem_stage_tb.sv

//--- verilog/ls_request.sv
// stage handshake control
// generates e2m_ready, the accept strobe and the data memory request
`timescale 1ns/100ps

module ls_request
   import mem_stage_pkg::*;
(
   input  logic      e2m_valid,
   input  e2m_t      e2m,
   input  logic      pipe_full,                          // wb pipe holds a word
   input  logic      m2w_ready,                          // wb stage pops this cycle
   input  logic      mio_rsp_ack,
   output logic      e2m_ready,
   output logic      accept,                             // instruction taken this cycle
   output logic      mio_req_valid,
   output mio_req_t  mio_req
);

   logic is_ld;
   logic is_st;
   logic is_ls;
   logic room;

   assign is_ld = (e2m.i_type == LD);
   assign is_st = (e2m.i_type == ST);
   assign is_ls = is_ld | is_st;

   // pipe can take a word if empty or being popped now
   assign room = !pipe_full | m2w_ready;

   // loads and stores also wait for the memory ack
   assign e2m_ready = room & (!is_ls | mio_rsp_ack);
   assign accept    = e2m_valid & e2m_ready;

   // ------------------------------------------------------------------------
   // data memory request
   // ------------------------------------------------------------------------
   assign mio_req_valid = e2m_valid & is_ls & room;  // held until ack, execute keeps e2m stable

   assign mio_req.rd       = is_ld;                      // read
   assign mio_req.wr       = is_st;                      // write
   assign mio_req.addr     = e2m.ls_addr;
   assign mio_req.wr_data  = e2m.st_data;
   assign mio_req.size     = e2m.size;
   assign mio_req.zero_ext = e2m.zero_ext;               // LBU / LHU

endmodule

//--- verilog/mem_stage.sv
// memory stage top
// handshake, retire check, trap registers and the writeback pipe
`timescale 1ns/100ps

module mem_stage
   import mem_stage_pkg::*;
(
   input  logic       clk_in,
   input  logic       rst_n,
   input  logic       pipe_flush,
   input  logic       e2m_valid,
   input  e2m_t       e2m,
   output logic       e2m_ready,
   output logic       mio_req_valid,
   output mio_req_t   mio_req,
   input  mio_rsp_t   mio_rsp,
   output logic       m2w_valid,
   input  logic       m2w_ready,
   output wb_t        m2w,
   output fwd_t       fwd,                               // gpr forwarding
   output events_t    events,
   output reload_t    reload,
   input  cfg_wr_t    cfg_wr,
   output trap_rec_t  trap_rec
);

   logic             accept;
   logic             pipe_full;
   logic             wb_write;
   wb_t              wb;
   exc_t             exc;
   logic [XLEN-1:0]  trap_pc;
   logic [1:0]       mode;

   trap_csr trap_csr_inst (
      .clk_in(clk_in), .rst_n(rst_n), .cfg_wr(cfg_wr), .exc(exc),
      .trap_pc(trap_pc), .mode(mode), .trap_rec(trap_rec)
   );

   ls_request ls_request_inst (
      .e2m_valid(e2m_valid), .e2m(e2m), .pipe_full(pipe_full), .m2w_ready(m2w_ready),
      .mio_rsp_ack(mio_rsp.ack), .e2m_ready(e2m_ready), .accept(accept),
      .mio_req_valid(mio_req_valid), .mio_req(mio_req)
   );

   retire_check retire_check_inst (
      .accept(accept), .e2m(e2m), .mio_rsp(mio_rsp), .trap_pc(trap_pc), .mode(mode),
      .wb_write(wb_write), .wb(wb), .fwd(fwd), .exc(exc), .events(events),
      .reload(reload)
   );

   wb_pipe wb_pipe_inst (
      .clk_in(clk_in), .rst_n(rst_n), .pipe_flush(pipe_flush), .wr(wb_write),
      .din(wb), .m2w_ready(m2w_ready), .full(pipe_full), .m2w_valid(m2w_valid),
      .m2w(m2w)
   );

endmodule

//--- verilog/mem_stage_pkg.sv
// memory stage package
// widths, exception causes, instruction classes and the port structs
// shared by the memory stage blocks
package mem_stage_pkg;

   // ------------------------------------------------------------------------
   // widths and codes
   // ------------------------------------------------------------------------
   localparam int XLEN    = 32;                          // data and address width
   localparam int GPR_ASZ = 5;                           // gpr address width
   localparam int OP_SZ   = 4;                           // op word width
   localparam int CAUSE_W = 4;                           // exception cause width
   localparam int NUM_RET = 11;                          // retire event classes

   localparam logic [CAUSE_W-1:0] CAUSE_MISALIGN_BR = 4'd0;  // branch target misaligned
   localparam logic [CAUSE_W-1:0] CAUSE_CSR_FAULT   = 4'd1;  // csr access fault
   localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL     = 4'd2;
   localparam logic [CAUSE_W-1:0] CAUSE_BREAK       = 4'd3;
   localparam logic [CAUSE_W-1:0] CAUSE_LD_MISALIGN = 4'd4;
   localparam logic [CAUSE_W-1:0] CAUSE_LD_FAULT    = 4'd5;
   localparam logic [CAUSE_W-1:0] CAUSE_ST_MISALIGN = 4'd6;
   localparam logic [CAUSE_W-1:0] CAUSE_ST_FAULT    = 4'd7;
   localparam logic [CAUSE_W-1:0] CAUSE_ECALL       = 4'd8;  // plus the calling mode

   localparam logic [1:0] U_MODE = 2'b00;                // user
   localparam logic [1:0] M_MODE = 2'b11;                // machine

   // ------------------------------------------------------------------------
   // instruction classes and ops
   // ------------------------------------------------------------------------
   typedef enum logic [3:0] {ILL, ALU, BR, IM, IDR, SYS, CSR, LD, ST} i_type_e;

   typedef enum logic [OP_SZ-1:0] {MRET, BXX, JAL, JALR} br_op_e;
   typedef enum logic [OP_SZ-1:0] {ECALL, EBREAK} sys_op_e;

   typedef union packed {
      br_op_e  br;                                       // view for BR class
      sys_op_e sys;                                      // view for SYS class
   } op_u;

   typedef enum logic [3:0] {
      RET_UNK, RET_ALU, RET_BXX, RET_JAL, RET_JALR, RET_IM,
      RET_IDR, RET_SYS, RET_CSR, RET_LD, RET_ST
   } ret_class_e;

   typedef enum logic {CFG_VEC, CFG_MODE} cfg_sel_e;

   // ------------------------------------------------------------------------
   // port structs
   // ------------------------------------------------------------------------
   typedef struct packed {
      i_type_e             i_type;
      op_u                 op;
      logic [XLEN-1:0]     pc;
      logic [XLEN-1:0]     instr;                        // raw instruction word
      logic                rd_wr;
      logic [GPR_ASZ-1:0]  rd_addr;
      logic [XLEN-1:0]     rd_data;
      logic [XLEN-1:0]     ls_addr;
      logic [XLEN-1:0]     st_data;
      logic [2:0]          size;
      logic                zero_ext;                     // LBU / LHU
      logic                inv_flag;                     // store hit instruction space
      logic                mis;                          // misaligned or fault from execute
      logic                ci;                           // compressed instruction
      logic [XLEN-1:0]     br_pc;                        // resolved target
      logic [XLEN-1:0]     predicted_addr;
   } e2m_t;

   typedef struct packed {
      logic rd;
      logic wr;
      logic [XLEN-1:0] addr;
      logic [XLEN-1:0] wr_data;
      logic [2:0] size;
      logic zero_ext;
   } mio_req_t;

   typedef struct packed {
      logic ack;
      logic fault;
      logic [XLEN-1:0] data;                             // load data
   } mio_rsp_t;

   typedef struct packed {
      logic rd_wr;
      logic [GPR_ASZ-1:0] rd_addr;
      logic [XLEN-1:0] rd_data;
   } wb_t;

   typedef struct packed {
      logic valid;
      wb_t wb;
   } fwd_t;

   typedef struct packed {
      logic flag;
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] tval;
      logic [CAUSE_W-1:0] cause;
   } exc_t;

   typedef struct packed {
      logic [NUM_RET-1:0] ret;                           // one hot by ret_class_e
      logic e_flag;
      logic [CAUSE_W-1:0] e_cause;
      logic mispredict;
   } events_t;

   typedef struct packed {
      logic pc_flag;
      logic ic_flag;
      logic [XLEN-1:0] addr;
   } reload_t;

   typedef struct packed {
      logic valid;
      cfg_sel_e sel;
      logic [XLEN-1:0] data;
   } cfg_wr_t;

   typedef struct packed {
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] tval;
      logic [CAUSE_W-1:0] cause;
   } trap_rec_t;

endpackage

//--- verilog/retire_check.sv
// retire check
// classifies each accepted instruction into writeback, exception or
// fetch reload, and raises its retire events
`timescale 1ns/100ps

module retire_check
   import mem_stage_pkg::*;
(
   input  logic             accept,
   input  e2m_t             e2m,
   input  mio_rsp_t         mio_rsp,
   input  logic [XLEN-1:0]  trap_pc,
   input  logic [1:0]       mode,
   output logic             wb_write,                    // load the wb pipe
   output wb_t              wb,
   output fwd_t             fwd,
   output exc_t             exc,
   output events_t          events,
   output reload_t          reload
);

   logic                exc_hit;                         // instruction traps
   logic [CAUSE_W-1:0]  exc_cause;
   logic [XLEN-1:0]     exc_tval;
   logic                br_miss;                         // target differs from prediction
   logic                ld_fault;
   ret_class_e          ret_cls;

   assign br_miss  = (e2m.predicted_addr != e2m.br_pc);
   assign ld_fault = mio_rsp.ack & mio_rsp.fault;        // reused for store faults

   always_comb
   begin
      exc_hit   = 1'b0;
      exc_cause = '0;
      exc_tval  = e2m.instr;                             // most traps report the word
      ret_cls   = RET_UNK;
      wb        = '0;
      exc       = '0;
      events    = '0;
      reload    = '0;

      if (accept)
      begin
         unique case (e2m.i_type)
            ALU, IM, IDR:
            begin
               wb = '{e2m.rd_wr, e2m.rd_addr, e2m.rd_data};
               ret_cls = (e2m.i_type == ALU) ? RET_ALU : (e2m.i_type == IM) ? RET_IM : RET_IDR;
            end
            BR:
            begin
               ret_cls = RET_BXX;                        // MRET counts as a branch
               if (e2m.op.br == JAL)
                  ret_cls = RET_JAL;
               else if (e2m.op.br == JALR)
                  ret_cls = RET_JALR;
               if (e2m.op.br == MRET)
               begin
                  if (mode < M_MODE)                     // privileged in user mode
                  begin
                     exc_hit   = 1'b1;
                     exc_cause = CAUSE_ILLEGAL;
                  end
                  else
                     events.mispredict = br_miss;
               end
               else if (!(e2m.op.br inside {BXX, JAL, JALR}))
               begin
                  exc_hit   = 1'b1;                      // undefined branch op
                  exc_cause = CAUSE_ILLEGAL;
                  ret_cls   = RET_UNK;
               end
               else if (e2m.mis)
               begin
                  exc_hit   = 1'b1;
                  exc_cause = CAUSE_MISALIGN_BR;
                  exc_tval  = e2m.br_pc;                 // misaligned target
               end
               else if (br_miss)
                  events.mispredict = 1'b1;              // jumps write nothing on a miss
               else if (e2m.op.br != BXX)
                  wb = '{e2m.rd_wr, e2m.rd_addr, e2m.rd_data};   // link address
            end
            SYS:
            begin
               ret_cls = RET_SYS;
               exc_hit = 1'b1;                           // every sys op traps here
               if (e2m.op.sys == ECALL)
                  exc_cause = CAUSE_ECALL | CAUSE_W'(mode);  // 8 + mode
               else if (e2m.op.sys == EBREAK)
                  exc_cause = CAUSE_BREAK;
               else
                  exc_cause = CAUSE_ILLEGAL;
            end
            CSR:
            begin
               ret_cls = RET_CSR;
               if (e2m.mis)
               begin
                  exc_hit   = 1'b1;
                  exc_cause = CAUSE_CSR_FAULT;
                  exc_tval  = e2m.rd_data;               // execute leaves the csr address here
               end
               else
                  wb = '{e2m.rd_wr, e2m.rd_addr, e2m.rd_data};
            end
            LD, ST:
            begin
               ret_cls  = (e2m.i_type == LD) ? RET_LD : RET_ST;
               exc_tval = e2m.ls_addr;
               if (e2m.mis | ld_fault)
               begin
                  exc_hit   = 1'b1;
                  exc_cause = (e2m.i_type == LD) ? CAUSE_LD_MISALIGN : CAUSE_ST_MISALIGN;
                  if (!e2m.mis)
                     exc_cause = exc_cause + 1'b1;       // fault is misalign + 1
               end
               else if (e2m.i_type == LD)
                  wb = '{e2m.rd_wr, e2m.rd_addr, mio_rsp.data};
               else if (e2m.inv_flag)
               begin
                  reload.pc_flag = 1'b1;                 // store into instruction space
                  reload.ic_flag = 1'b1;
                  reload.addr    = e2m.pc + (e2m.ci ? XLEN'(2) : XLEN'(4));
               end
            end
            default:
            begin
               exc_hit   = 1'b1;                         // ILL and unknown classes
               exc_cause = CAUSE_ILLEGAL;
            end
         endcase

         if (exc_hit)
         begin
            exc            = '{1'b1, e2m.pc, exc_tval, exc_cause};
            reload.pc_flag = 1'b1;                       // redirect fetch to the handler
            reload.addr    = trap_pc;
            events.e_flag  = 1'b1;
            events.e_cause = exc_cause;
         end
         events.ret[ret_cls] = 1'b1;
      end
   end

   assign wb_write  = accept & wb.rd_wr;                 // only real writes enter the pipe
   assign fwd.valid = accept;
   assign fwd.wb    = wb;

endmodule

//--- verilog/trap_csr.sv
// trap register block
// holds the trap vector and privilege mode, records the last exception
`timescale 1ns/100ps

module trap_csr
   import mem_stage_pkg::*;
(
   input  logic             clk_in,
   input  logic             rst_n,
   input  cfg_wr_t          cfg_wr,                      // config write port
   input  exc_t             exc,                         // exception from retire check
   output logic [XLEN-1:0]  trap_pc,                     // trap vector
   output logic [1:0]       mode,                        // current privilege
   output trap_rec_t        trap_rec                     // last exception taken
);

   logic vec_we;
   logic mode_we;

   assign vec_we  = cfg_wr.valid & (cfg_wr.sel == CFG_VEC);
   assign mode_we = cfg_wr.valid & (cfg_wr.sel == CFG_MODE);

   // ------------------------------------------------------------------------
   // trap vector and mode
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (!rst_n)
         trap_pc <= '0;                                  // vector at address 0
      else if (vec_we)
         trap_pc <= cfg_wr.data;
   end

   always_ff @(posedge clk_in)
   begin
      if (!rst_n)
         mode <= M_MODE;                                 // come out of reset in machine mode
      else if (mode_we)
         mode <= cfg_wr.data[1:0];
   end

   // ------------------------------------------------------------------------
   // exception record
   // ------------------------------------------------------------------------
   // captured one cycle after the accept that raised it
   always_ff @(posedge clk_in)
   begin
      if (exc.flag)
      begin
         trap_rec.pc    <= exc.pc;                       // faulting instruction
         trap_rec.tval  <= exc.tval;                     // bad address or instruction word
         trap_rec.cause <= exc.cause;
      end
   end

endmodule

//--- verilog/wb_pipe.sv
// writeback pipe register
// one entry with full flag, write and pop may share a cycle
`timescale 1ns/100ps

module wb_pipe
   import mem_stage_pkg::*;
(
   input  logic  clk_in,
   input  logic  rst_n,
   input  logic  pipe_flush,                             // drop the held word
   input  logic  wr,
   input  wb_t   din,
   input  logic  m2w_ready,
   output logic  full,
   output logic  m2w_valid,
   output wb_t   m2w
);

   wb_t  data_q;                                         // held result
   logic pop;

   assign pop = full & m2w_ready;

   always_ff @(posedge clk_in)
   begin
      if (!rst_n || pipe_flush)
         full <= 1'b0;                                   // flush beats a same-cycle write
      else if (wr)
         full <= 1'b1;                                   // write with or without pop
      else if (pop)
         full <= 1'b0;
   end

   always_ff @(posedge clk_in)
   begin
      if (wr)
         data_q <= din;
   end

   assign m2w_valid = full;
   assign m2w       = data_q;

endmodule
